/* project.f */
mipsPkg.sv
decodeIf.sv
instrDecode.sv
aluUnit.sv
regFile.sv
cpuControl.sv
mipsCpuBus.sv
tbMemory.sv
tbMipsCpuBus.sv

/* run.sh */
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ns \
    --top-module tbMipsCpuBus -f project.f -o simMips

./obj_dir/simMips | tee sim.log

if grep -q "STATUS: FAIL" sim.log; then
    echo "Simulation reported failure"
    exit 1
fi
echo "Simulation finished without failure"

/* tbMipsCpuBus.sv */
`timescale 1ns/1ns
`default_nettype none

module tbMipsCpuBus;

    localparam int             PROG_WORDS   = 60;
    localparam int             DATA_WORDS   = 64;
    localparam mipsPkg::word_t DATA_BASE    = 32'h0000_1000;
    localparam int             WAIT_PERCENT = 30;
    localparam int             MAX_WAIT     = 3;
    localparam int             SEED         = 87;
    localparam int             CLK_PERIOD   = 20;
    // Two stalled transfers per instruction at worst
    localparam int WATCHDOG_NS = (PROG_WORDS * (5 + 2 * MAX_WAIT) + 100) * CLK_PERIOD;

    localparam mipsPkg::func_t ALU_FUNCS [7] = '{
        mipsPkg::FN_ADDU, mipsPkg::FN_SUBU, mipsPkg::FN_AND, mipsPkg::FN_OR,
        mipsPkg::FN_XOR, mipsPkg::FN_SLT, mipsPkg::FN_SLTU
    };
    localparam mipsPkg::opcode_t IMM_OPS [7] = '{
        mipsPkg::OP_ADDIU, mipsPkg::OP_SLTI, mipsPkg::OP_SLTIU, mipsPkg::OP_ANDI,
        mipsPkg::OP_ORI, mipsPkg::OP_XORI, mipsPkg::OP_LUI
    };

    logic           clk = 1'b0;
    logic           rst;
    logic           active;
    logic           write;
    logic           read;
    logic           waitrequest;
    logic [3:0]     byteenable;
    mipsPkg::word_t registerV0;
    mipsPkg::word_t address;
    mipsPkg::word_t writedata;
    mipsPkg::word_t readdata;

    mipsPkg::word_t prog [PROG_WORDS];
    mipsPkg::word_t expAddr [$];
    mipsPkg::word_t expData [$];
    mipsPkg::word_t expV0;
    mipsPkg::word_t addrPrev;
    mipsPkg::word_t dataPrev;
    logic [1:0]     ctrlPrev;
    logic           stallPrev = 1'b0;
    logic           haltSeen = 1'b0;
    int             storeCount = 0;
    int             valueErrors = 0;
    int             protocolErrors = 0;

    mipsCpuBus DUT (
        .clk(clk), .rst(rst), .active(active), .registerV0(registerV0),
        .address(address), .write(write), .read(read), .waitrequest(waitrequest),
        .writedata(writedata), .byteenable(byteenable), .readdata(readdata)
    );

    tbMemory #(
        .ROM_WORDS(PROG_WORDS), .DATA_WORDS(DATA_WORDS), .DATA_BASE(DATA_BASE),
        .WAIT_PERCENT(WAIT_PERCENT), .MAX_WAIT(MAX_WAIT)
    ) memory (
        .clk(clk), .address(address), .read(read), .write(write),
        .writedata(writedata), .waitrequest(waitrequest), .readdata(readdata)
    );

    initial begin
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic int randBelow(int n);
        return int'($urandom % n);
    endfunction

    // Initial data contents, a mix of every address bit
    function automatic mipsPkg::word_t fillWord(mipsPkg::word_t addr);
        return {addr[15:0] ^ 16'hC3A5, ~addr[15:0]} + (addr >> 2) * 32'h9E37_79B9;
    endfunction

    function automatic mipsPkg::word_t encodeR(mipsPkg::func_t fn, int rs, int rt, int rd);
        return {mipsPkg::OP_RTYPE, 5'(rs), 5'(rt), 5'(rd), 5'd0, fn};
    endfunction

    function automatic mipsPkg::word_t encodeI(mipsPkg::opcode_t op, int rs, int rt,
                                               mipsPkg::imm_t imm);
        return {op, 5'(rs), 5'(rt), imm};
    endfunction

    task automatic reportMismatch(string name, mipsPkg::word_t got, mipsPkg::word_t expected);
        $display("FAIL t=%0t %s got 0x%08h expected 0x%08h", $time, name, got, expected);
        valueErrors++;
    endtask

    task automatic buildProgram();
        int i;
        int kind;
        int room;
        int rs;
        i = 0;
        while (i < PROG_WORDS - 2) begin
            kind = randBelow(10);
            // Control transfers need a delay slot and a forward target
            if (kind >= 7 && i > PROG_WORDS - 4) begin
                kind = 3;
            end
            room = PROG_WORDS - 3 - i;
            if (room > 4) begin
                room = 4;
            end
            case (kind)
                0, 1, 2: prog[i] = encodeR(ALU_FUNCS[randBelow(7)], randBelow(8), randBelow(8),
                                           1 + randBelow(7));
                3, 4: prog[i] = encodeI(IMM_OPS[randBelow(7)], randBelow(8), 1 + randBelow(7),
                                        16'($urandom));
                5: prog[i] = encodeI(mipsPkg::OP_LW, 0, 1 + randBelow(7),
                                     16'(DATA_BASE + 4 * randBelow(DATA_WORDS)));
                6: prog[i] = encodeI(mipsPkg::OP_SW, 0, randBelow(8),
                                     16'(DATA_BASE + 4 * randBelow(DATA_WORDS)));
                7, 8: begin
                    rs = randBelow(8);
                    prog[i] = encodeI(randBelow(2) == 0 ? mipsPkg::OP_BEQ : mipsPkg::OP_BNE,
                                      rs, randBelow(4) == 0 ? rs : randBelow(8),
                                      16'(1 + randBelow(room)));
                end
                default: prog[i] = {mipsPkg::OP_J,
                    26'((mipsPkg::RESET_VECTOR + 4 * (i + 2 + randBelow(room))) >> 2)};
            endcase
            if (kind >= 7) begin
                prog[i + 1] = '0;
                i += 2;
            end else begin
                i += 1;
            end
        end
        prog[PROG_WORDS - 2] = encodeR(mipsPkg::FN_JR, 0, 0, 0);
        prog[PROG_WORDS - 1] = '0;
        for (int k = 0; k < PROG_WORDS; k++) begin
            memory.rom[k] = prog[k];
        end
        for (int k = 0; k < DATA_WORDS; k++) begin
            memory.dataMem[k] = fillWord(DATA_BASE + 32'(4 * k));
        end
    endtask

    // Instruction-set model: one instruction per step, one delay slot
    task automatic runModel();
        mipsPkg::word_t regs [32];
        mipsPkg::word_t data [DATA_WORDS];
        mipsPkg::word_t pc, ins, a, b, sImm, zImm, wrVal, target, pendTarget, addr;
        logic pending, taken, doWrite;
        int steps, idx, wrIdx;
        for (int k = 0; k < 32; k++) begin
            regs[k] = '0;
        end
        for (int k = 0; k < DATA_WORDS; k++) begin
            data[k] = fillWord(DATA_BASE + 32'(4 * k));
        end
        pc = mipsPkg::RESET_VECTOR;
        pending = 1'b0;
        pendTarget = '0;
        steps = 0;
        while (pc != mipsPkg::HALT_ADDRESS && steps < 1000) begin
            idx = int'((pc - mipsPkg::RESET_VECTOR) >> 2);
            ins = (idx < PROG_WORDS) ? prog[idx] : '0;
            a = regs[ins[25:21]];
            b = regs[ins[20:16]];
            sImm = {{16{ins[15]}}, ins[15:0]};
            zImm = {16'd0, ins[15:0]};
            addr = a + sImm;
            wrIdx = int'(ins[20:16]);
            wrVal = '0;
            doWrite = 1'b1;
            taken = 1'b0;
            target = '0;
            case (ins[31:26])
                mipsPkg::OP_RTYPE: begin
                    wrIdx = int'(ins[15:11]);
                    case (ins[5:0])
                        mipsPkg::FN_ADDU: wrVal = a + b;
                        mipsPkg::FN_SUBU: wrVal = a - b;
                        mipsPkg::FN_AND:  wrVal = a & b;
                        mipsPkg::FN_OR:   wrVal = a | b;
                        mipsPkg::FN_XOR:  wrVal = a ^ b;
                        mipsPkg::FN_SLT:  wrVal = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        mipsPkg::FN_SLTU: wrVal = (a < b) ? 32'd1 : 32'd0;
                        mipsPkg::FN_JR: begin
                            doWrite = 1'b0;
                            taken = 1'b1;
                            target = a;
                        end
                        default: doWrite = 1'b0;
                    endcase
                end
                mipsPkg::OP_ADDIU: wrVal = a + sImm;
                mipsPkg::OP_SLTI:  wrVal = ($signed(a) < $signed(sImm)) ? 32'd1 : 32'd0;
                mipsPkg::OP_SLTIU: wrVal = (a < sImm) ? 32'd1 : 32'd0;
                mipsPkg::OP_ANDI:  wrVal = a & zImm;
                mipsPkg::OP_ORI:   wrVal = a | zImm;
                mipsPkg::OP_XORI:  wrVal = a ^ zImm;
                mipsPkg::OP_LUI:   wrVal = zImm << 16;
                mipsPkg::OP_LW:    wrVal = data[int'((addr - DATA_BASE) >> 2)];
                mipsPkg::OP_SW: begin
                    doWrite = 1'b0;
                    data[int'((addr - DATA_BASE) >> 2)] = b;
                    expAddr.push_back(addr);
                    expData.push_back(b);
                end
                mipsPkg::OP_BEQ, mipsPkg::OP_BNE: begin
                    doWrite = 1'b0;
                    taken = (ins[31:26] == mipsPkg::OP_BEQ) ? (a == b) : (a != b);
                    target = pc + 32'd4 + (sImm << 2);
                end
                mipsPkg::OP_J: begin
                    doWrite = 1'b0;
                    taken = 1'b1;
                    target = {pc[31:28], ins[25:0], 2'b00};
                end
                default: doWrite = 1'b0;
            endcase
            if (doWrite && wrIdx != 0) begin
                regs[wrIdx] = wrVal;
            end
            if (pending) begin
                pc = pendTarget;
                pending = 1'b0;
            end else begin
                pc = pc + 32'd4;
                pending = taken;
                pendTarget = target;
            end
            steps++;
        end
        if (pc != mipsPkg::HALT_ADDRESS) begin
            $display("Reference model never reached the halt address");
            protocolErrors++;
        end
        expV0 = regs[mipsPkg::V0_INDEX];
    endtask

    // Called once per rising edge, sees the values of the cycle just ending
    task automatic sampleBus();
        if (stallPrev) begin
            if (address !== addrPrev) reportMismatch("address", address, addrPrev);
            if (writedata !== dataPrev) reportMismatch("writedata", writedata, dataPrev);
            if ({read, write} !== ctrlPrev) begin
                reportMismatch("read/write", {30'd0, read, write}, {30'd0, ctrlPrev});
            end
        end
        if (write === 1'b1 && waitrequest === 1'b0) begin
            if (storeCount < expAddr.size()) begin
                if (address !== expAddr[storeCount]) begin
                    reportMismatch("address", address, expAddr[storeCount]);
                end
                if (writedata !== expData[storeCount]) begin
                    reportMismatch("writedata", writedata, expData[storeCount]);
                end
                if (byteenable !== 4'b1111) begin
                    reportMismatch("byteenable", {28'd0, byteenable}, 32'h0000_000F);
                end
            end else begin
                $display("Store at t=%0t to 0x%08h is more than the model expects", $time,
                         address);
                protocolErrors++;
            end
            storeCount++;
        end
        if (active !== 1'b1 && (read === 1'b1 || write === 1'b1)) begin
            $display("Bus transfer at t=%0t after the CPU halted", $time);
            protocolErrors++;
        end
        if (haltSeen && active === 1'b1) begin
            $display("active rose again at t=%0t after the halt", $time);
            protocolErrors++;
        end
        haltSeen = haltSeen || (active !== 1'b1);
        stallPrev = (read === 1'b1 || write === 1'b1) && waitrequest === 1'b1;
        addrPrev = address;
        dataPrev = writedata;
        ctrlPrev = {read, write};
    endtask

    initial begin
        void'($urandom(SEED));
        rst = 1'b1;
        buildProgram();
        runModel();
        repeat (8) @(negedge clk);
        rst = 1'b0;
        if (write !== 1'b0) reportMismatch("write", {31'd0, write}, 32'd0);
        if (active !== 1'b1) reportMismatch("active", {31'd0, active}, 32'd1);
        if (read !== 1'b1) reportMismatch("read", {31'd0, read}, 32'd1);
        if (address !== mipsPkg::RESET_VECTOR) begin
            reportMismatch("address", address, mipsPkg::RESET_VECTOR);
        end
        while (active === 1'b1) begin
            @(posedge clk);
            sampleBus();
        end
        // A few idle cycles to see the bus stay quiet
        repeat (4) begin
            @(posedge clk);
            sampleBus();
        end
        if (registerV0 !== expV0) reportMismatch("registerV0", registerV0, expV0);
        if (memory.writeAddr.size() != expAddr.size()) begin
            $display("Bus saw %0d stores but the model expects %0d", memory.writeAddr.size(),
                     expAddr.size());
            protocolErrors++;
        end
        // Slave-side log against the model
        for (int k = 0; k < memory.writeAddr.size() && k < expAddr.size(); k++) begin
            if (memory.writeAddr[k] !== expAddr[k]) begin
                reportMismatch("logged store address", memory.writeAddr[k], expAddr[k]);
            end
            if (memory.writeData[k] !== expData[k]) begin
                reportMismatch("logged store data", memory.writeData[k], expData[k]);
            end
        end
        $display("Errors: %0d value, %0d protocol; stores %0d of %0d", valueErrors,
                 protocolErrors, storeCount, expAddr.size());
        if (valueErrors == 0 && protocolErrors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the CPU did not halt within %0d ns", WATCHDOG_NS);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

/* tbMemory.sv */
`timescale 1ns/1ns
`default_nettype none

module tbMemory #(
    parameter int             ROM_WORDS    = 64,
    parameter int             DATA_WORDS   = 64,
    parameter mipsPkg::word_t DATA_BASE    = 32'h0000_1000,
    parameter int             WAIT_PERCENT = 30,
    parameter int             MAX_WAIT     = 3
) (
    input  logic           clk,
    input  mipsPkg::word_t address,
    input  logic           read,
    input  logic           write,
    input  mipsPkg::word_t writedata,
    output logic           waitrequest,
    output mipsPkg::word_t readdata
);

    // Program window at the reset vector, filled by the testbench
    mipsPkg::word_t rom [ROM_WORDS];
    mipsPkg::word_t dataMem [DATA_WORDS];

    // Completed writes in bus order
    mipsPkg::word_t writeAddr [$];
    mipsPkg::word_t writeData [$];

    mipsPkg::word_t nextReaddata;
    logic stall;
    int waitRun;

    function automatic mipsPkg::word_t readWord(mipsPkg::word_t addr);
        mipsPkg::word_t romOffset;
        mipsPkg::word_t dataOffset;
        romOffset = addr - mipsPkg::RESET_VECTOR;
        dataOffset = addr - DATA_BASE;
        if (romOffset < 32'(4 * ROM_WORDS)) begin
            return rom[int'(romOffset >> 2)];
        end
        if (dataOffset < 32'(4 * DATA_WORDS)) begin
            return dataMem[int'(dataOffset >> 2)];
        end
        return '0;
    endfunction

    initial begin
        waitrequest = 1'b0;
        readdata = '0;
        nextReaddata = '0;
        waitRun = 0;
        forever begin
            @(negedge clk);
            // Data of a read completed at the last rising edge
            readdata = nextReaddata;
            stall = (waitRun < MAX_WAIT) && (($urandom % 100) < WAIT_PERCENT);
            waitRun = stall ? waitRun + 1 : 0;
            if (read && !stall) begin
                nextReaddata = readWord(address);
            end
            if (write && !stall) begin
                if (address - DATA_BASE < 32'(4 * DATA_WORDS)) begin
                    dataMem[int'((address - DATA_BASE) >> 2)] = writedata;
                end
                writeAddr.push_back(address);
                writeData.push_back(writedata);
            end
            waitrequest = stall;
        end
    end

endmodule

`default_nettype wire

/* mipsCpuBus.sv */
`timescale 1ns/1ns
`default_nettype none

module mipsCpuBus (
    input  logic           clk,
    input  logic           rst,
    output logic           active,
    output mipsPkg::word_t registerV0,
    output mipsPkg::word_t address,
    output logic           write,
    output logic           read,
    input  logic           waitrequest,
    output mipsPkg::word_t writedata,
    output logic [3:0]     byteenable,
    input  mipsPkg::word_t readdata
);

    mipsPkg::word_t    instr;
    mipsPkg::regAddr_t rdAddrA;
    mipsPkg::regAddr_t rdAddrB;
    mipsPkg::word_t    rdDataA;
    mipsPkg::word_t    rdDataB;
    logic              wrEn;
    mipsPkg::regAddr_t wrAddr;
    mipsPkg::word_t    wrData;
    mipsPkg::aluOp_t   aluOp;
    mipsPkg::word_t    aluA;
    mipsPkg::word_t    aluB;
    mipsPkg::word_t    aluResult;
    logic              aluZero;

    decodeIf decBus ();

    cpuControl control (
        .clk(clk), .rst(rst), .dec(decBus.control), .instr(instr),
        .rdAddrA(rdAddrA), .rdAddrB(rdAddrB), .rdDataA(rdDataA), .rdDataB(rdDataB),
        .wrEn(wrEn), .wrAddr(wrAddr), .wrData(wrData),
        .aluOp(aluOp), .aluA(aluA), .aluB(aluB), .aluResult(aluResult), .aluZero(aluZero),
        .address(address), .write(write), .read(read), .waitrequest(waitrequest),
        .writedata(writedata), .byteenable(byteenable), .readdata(readdata),
        .active(active)
    );

    instrDecode decoder (.instr(instr), .dec(decBus.decoder));

    aluUnit alu (.op(aluOp), .a(aluA), .b(aluB), .result(aluResult), .zero(aluZero));

    regFile regs (
        .clk(clk), .rst(rst),
        .rdAddrA(rdAddrA), .rdAddrB(rdAddrB), .rdDataA(rdDataA), .rdDataB(rdDataB),
        .wrEn(wrEn), .wrAddr(wrAddr), .wrData(wrData), .registerV0(registerV0)
    );

endmodule

`default_nettype wire

/* cpuControl.sv */
`timescale 1ns/1ns
`default_nettype none

module cpuControl (
    input  logic              clk,
    input  logic              rst,
    decodeIf.control          dec,
    output mipsPkg::word_t    instr,
    output mipsPkg::regAddr_t rdAddrA,
    output mipsPkg::regAddr_t rdAddrB,
    input  mipsPkg::word_t    rdDataA,
    input  mipsPkg::word_t    rdDataB,
    output logic              wrEn,
    output mipsPkg::regAddr_t wrAddr,
    output mipsPkg::word_t    wrData,
    output mipsPkg::aluOp_t   aluOp,
    output mipsPkg::word_t    aluA,
    output mipsPkg::word_t    aluB,
    input  mipsPkg::word_t    aluResult,
    input  logic              aluZero,
    output mipsPkg::word_t    address,
    output logic              write,
    output logic              read,
    input  logic              waitrequest,
    output mipsPkg::word_t    writedata,
    output logic [3:0]        byteenable,
    input  mipsPkg::word_t    readdata,
    output logic              active
);

    mipsPkg::cpuState_t state;
    mipsPkg::word_t pc;
    mipsPkg::word_t pcPlus4;
    mipsPkg::word_t branchTarget;
    mipsPkg::word_t nextTarget;
    mipsPkg::imm_t imm;
    logic delaySlot;
    logic taken;
    logic memAccess;

    assign imm = instr[15:0];
    assign pcPlus4 = pc + 32'd4;
    assign memAccess = dec.isLoad | dec.isStore;

    // Operands stay latched through WRITEBACK, so the flag is still valid there
    always_comb begin
        case (dec.jumpKind)
            mipsPkg::JMP_BEQ:  taken = aluZero;
            mipsPkg::JMP_BNE:  taken = !aluZero;
            mipsPkg::JMP_JUMP: taken = 1'b1;
            mipsPkg::JMP_JREG: taken = 1'b1;
            default:           taken = 1'b0;
        endcase
        case (dec.jumpKind)
            mipsPkg::JMP_JUMP: nextTarget = {pc[31:28], instr[25:0], 2'b00};
            mipsPkg::JMP_JREG: nextTarget = rdDataA;
            default:           nextTarget = pcPlus4 + {{14{imm[15]}}, imm, 2'b00};
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= mipsPkg::ST_FETCH;
            pc <= mipsPkg::RESET_VECTOR;
            delaySlot <= 1'b0;
        end else begin
            case (state)
                mipsPkg::ST_FETCH: begin
                    if (pc == mipsPkg::HALT_ADDRESS) begin
                        state <= mipsPkg::ST_HALTED;
                    end else if (!waitrequest) begin
                        state <= mipsPkg::ST_DECODE;
                    end
                end
                mipsPkg::ST_DECODE: state <= mipsPkg::ST_EXEC;
                mipsPkg::ST_EXEC:   state <= mipsPkg::ST_MEM;
                mipsPkg::ST_MEM: begin
                    if (!(memAccess && waitrequest)) begin
                        state <= mipsPkg::ST_WRITEBACK;
                    end
                end
                mipsPkg::ST_WRITEBACK: begin
                    state <= mipsPkg::ST_FETCH;
                    if (delaySlot) begin
                        // Slot instruction done, now redirect
                        pc <= branchTarget;
                        delaySlot <= 1'b0;
                    end else begin
                        pc <= pcPlus4;
                        delaySlot <= taken;
                    end
                end
                default: state <= mipsPkg::ST_HALTED;
            endcase
        end
    end

    // Instruction and operand latches
    always_ff @(posedge clk) begin
        if (state == mipsPkg::ST_DECODE) begin
            instr <= readdata;
            rdAddrA <= readdata[25:21];
            rdAddrB <= readdata[20:16];
        end
        if (state == mipsPkg::ST_EXEC) begin
            aluOp <= dec.aluOp;
            aluA <= rdDataA;
            case (dec.immMode)
                mipsPkg::IMM_ZERO: aluB <= {16'd0, imm};
                mipsPkg::IMM_SIGN: aluB <= {{16{imm[15]}}, imm};
                default:           aluB <= rdDataB;
            endcase
        end
        if (state == mipsPkg::ST_WRITEBACK && !delaySlot && taken) begin
            branchTarget <= nextTarget;
        end
    end

    assign wrEn = (state == mipsPkg::ST_WRITEBACK) && dec.regWrite;
    assign wrAddr = dec.destReg;
    assign wrData = dec.isLoad ? readdata : aluResult;

    assign read = (state == mipsPkg::ST_FETCH && pc != mipsPkg::HALT_ADDRESS)
               || (state == mipsPkg::ST_MEM && dec.isLoad);
    assign write = (state == mipsPkg::ST_MEM) && dec.isStore;
    assign address = (state == mipsPkg::ST_FETCH) ? pc : aluResult;
    assign writedata = rdDataB;
    assign byteenable = (read || write) ? 4'b1111 : 4'b0000;
    assign active = (state != mipsPkg::ST_HALTED);

    assert property (@(posedge clk) disable iff (rst) !(read && write));
    assert property (@(posedge clk) disable iff (rst) (read || write) |-> (address[1:0] == 2'b00));

endmodule

`default_nettype wire

/* regFile.sv */
`timescale 1ns/1ns
`default_nettype none

module regFile (
    input  logic              clk,
    input  logic              rst,
    input  mipsPkg::regAddr_t rdAddrA,
    input  mipsPkg::regAddr_t rdAddrB,
    output mipsPkg::word_t    rdDataA,
    output mipsPkg::word_t    rdDataB,
    input  logic              wrEn,
    input  mipsPkg::regAddr_t wrAddr,
    input  mipsPkg::word_t    wrData,
    output mipsPkg::word_t    registerV0
);

    mipsPkg::word_t regs [32];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn && wrAddr != '0) begin
            regs[wrAddr] <= wrData;
        end
    end

    assign rdDataA = regs[rdAddrA];
    assign rdDataB = regs[rdAddrB];
    assign registerV0 = regs[mipsPkg::V0_INDEX];

    // $zero holds across every write since reset
    assert property (@(posedge clk) disable iff (rst) (rdAddrA == '0) |-> (rdDataA == '0));

endmodule

`default_nettype wire

/* aluUnit.sv */
`timescale 1ns/1ns
`default_nettype none

module aluUnit (
    input  mipsPkg::aluOp_t op,
    input  mipsPkg::word_t  a,
    input  mipsPkg::word_t  b,
    output mipsPkg::word_t  result,
    output logic            zero
);

    always_comb begin
        case (op)
            mipsPkg::ALU_ADD:   result = a + b;
            mipsPkg::ALU_SUB:   result = a - b;
            mipsPkg::ALU_AND:   result = a & b;
            mipsPkg::ALU_OR:    result = a | b;
            mipsPkg::ALU_XOR:   result = a ^ b;
            mipsPkg::ALU_SLT:   result = {31'd0, $signed(a) < $signed(b)};
            mipsPkg::ALU_SLTU:  result = {31'd0, a < b};
            // Immediate arrives zero-extended in b
            mipsPkg::ALU_LUI:   result = {b[15:0], 16'd0};
            mipsPkg::ALU_PASSA: result = a;
            default:            result = '0;
        endcase
    end

    assign zero = (result == '0);

endmodule

`default_nettype wire

/* instrDecode.sv */
`timescale 1ns/1ns
`default_nettype none

module instrDecode (
    input  mipsPkg::word_t instr,
    decodeIf.decoder       dec
);

    always_comb begin
        // Anything not listed below behaves as a NOP
        dec.aluOp    = mipsPkg::ALU_ADD;
        dec.immMode  = mipsPkg::IMM_SIGN;
        dec.regWrite = 1'b0;
        dec.destReg  = instr[20:16];
        dec.isLoad   = 1'b0;
        dec.isStore  = 1'b0;
        dec.jumpKind = mipsPkg::JMP_NONE;

        case (instr[31:26])
            mipsPkg::OP_RTYPE: begin
                dec.immMode = mipsPkg::IMM_REG;
                dec.destReg = instr[15:11];
                dec.regWrite = 1'b1;
                case (instr[5:0])
                    mipsPkg::FN_ADDU: dec.aluOp = mipsPkg::ALU_ADD;
                    mipsPkg::FN_SUBU: dec.aluOp = mipsPkg::ALU_SUB;
                    mipsPkg::FN_AND:  dec.aluOp = mipsPkg::ALU_AND;
                    mipsPkg::FN_OR:   dec.aluOp = mipsPkg::ALU_OR;
                    mipsPkg::FN_XOR:  dec.aluOp = mipsPkg::ALU_XOR;
                    mipsPkg::FN_SLT:  dec.aluOp = mipsPkg::ALU_SLT;
                    mipsPkg::FN_SLTU: dec.aluOp = mipsPkg::ALU_SLTU;
                    mipsPkg::FN_JR: begin
                        dec.aluOp = mipsPkg::ALU_PASSA;
                        dec.regWrite = 1'b0;
                        dec.jumpKind = mipsPkg::JMP_JREG;
                    end
                    default: dec.regWrite = 1'b0;
                endcase
            end
            mipsPkg::OP_ADDIU: dec.regWrite = 1'b1;
            mipsPkg::OP_SLTI: begin
                dec.aluOp = mipsPkg::ALU_SLT;
                dec.regWrite = 1'b1;
            end
            mipsPkg::OP_SLTIU: begin
                dec.aluOp = mipsPkg::ALU_SLTU;
                dec.regWrite = 1'b1;
            end
            mipsPkg::OP_ANDI: begin
                dec.aluOp = mipsPkg::ALU_AND;
                dec.immMode = mipsPkg::IMM_ZERO;
                dec.regWrite = 1'b1;
            end
            mipsPkg::OP_ORI: begin
                dec.aluOp = mipsPkg::ALU_OR;
                dec.immMode = mipsPkg::IMM_ZERO;
                dec.regWrite = 1'b1;
            end
            mipsPkg::OP_XORI: begin
                dec.aluOp = mipsPkg::ALU_XOR;
                dec.immMode = mipsPkg::IMM_ZERO;
                dec.regWrite = 1'b1;
            end
            mipsPkg::OP_LUI: begin
                dec.aluOp = mipsPkg::ALU_LUI;
                dec.immMode = mipsPkg::IMM_ZERO;
                dec.regWrite = 1'b1;
            end
            mipsPkg::OP_LW: begin
                dec.regWrite = 1'b1;
                dec.isLoad = 1'b1;
            end
            mipsPkg::OP_SW: dec.isStore = 1'b1;
            // Compare by subtraction, zero flag decides
            mipsPkg::OP_BEQ: begin
                dec.aluOp = mipsPkg::ALU_SUB;
                dec.immMode = mipsPkg::IMM_REG;
                dec.jumpKind = mipsPkg::JMP_BEQ;
            end
            mipsPkg::OP_BNE: begin
                dec.aluOp = mipsPkg::ALU_SUB;
                dec.immMode = mipsPkg::IMM_REG;
                dec.jumpKind = mipsPkg::JMP_BNE;
            end
            mipsPkg::OP_J: dec.jumpKind = mipsPkg::JMP_JUMP;
            default: ;
        endcase
    end

endmodule

`default_nettype wire

/* decodeIf.sv */
`timescale 1ns/1ns
`default_nettype none

interface decodeIf;

    mipsPkg::aluOp_t    aluOp;
    mipsPkg::immMode_t  immMode;
    logic               regWrite;
    mipsPkg::regAddr_t  destReg;
    logic               isLoad;
    logic               isStore;
    mipsPkg::jumpKind_t jumpKind;

    modport decoder (
        output aluOp, immMode, regWrite, destReg, isLoad, isStore, jumpKind
    );

    modport control (
        input aluOp, immMode, regWrite, destReg, isLoad, isStore, jumpKind
    );

endinterface

`default_nettype wire

/* mipsPkg.sv */
`default_nettype none

package mipsPkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  regAddr_t;
    typedef logic [15:0] imm_t;

    typedef enum logic [5:0] {
        OP_RTYPE = 6'b000000,
        OP_J     = 6'b000010,
        OP_BEQ   = 6'b000100,
        OP_BNE   = 6'b000101,
        OP_ADDIU = 6'b001001,
        OP_SLTI  = 6'b001010,
        OP_SLTIU = 6'b001011,
        OP_ANDI  = 6'b001100,
        OP_ORI   = 6'b001101,
        OP_XORI  = 6'b001110,
        OP_LUI   = 6'b001111,
        OP_LW    = 6'b100011,
        OP_SW    = 6'b101011
    } opcode_t;

    typedef enum logic [5:0] {
        FN_JR   = 6'b001000,
        FN_ADDU = 6'b100001,
        FN_SUBU = 6'b100011,
        FN_AND  = 6'b100100,
        FN_OR   = 6'b100101,
        FN_XOR  = 6'b100110,
        FN_SLT  = 6'b101010,
        FN_SLTU = 6'b101011
    } func_t;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
        ALU_SLT, ALU_SLTU, ALU_LUI, ALU_PASSA
    } aluOp_t;

    // Source of ALU operand B
    typedef enum logic [1:0] {IMM_REG, IMM_ZERO, IMM_SIGN} immMode_t;

    typedef enum logic [2:0] {JMP_NONE, JMP_BEQ, JMP_BNE, JMP_JUMP, JMP_JREG} jumpKind_t;

    typedef enum logic [2:0] {
        ST_FETCH     = 3'd0,
        ST_DECODE    = 3'd1,
        ST_EXEC      = 3'd2,
        ST_MEM       = 3'd3,
        ST_WRITEBACK = 3'd4,
        ST_HALTED    = 3'd7
    } cpuState_t;

    localparam word_t    RESET_VECTOR = 32'hBFC0_0000;
    localparam word_t    HALT_ADDRESS = 32'h0000_0000;
    localparam regAddr_t V0_INDEX     = 5'd2;

endpackage

`default_nettype wire
